/* hdl/sd_spi_defs.svh */
// Block size, SCLK divider, response timeout and APB address width macros
`ifndef SD_SPI_DEFS_SVH
`define SD_SPI_DEFS_SVH

// Bytes in one data block
`define SD_BLOCK_BYTES 16

// System clocks per SCLK half period
`define SD_SCLK_DIV 4

// SCLK bits to wait for a start bit
`define SD_RESP_TIMEOUT 64

`define SD_APB_ADDR_W 8

`endif

/* hdl/sd_spi_pkg.sv */
// Opcode, response kind and state enums, command and result structs
`include "sd_spi_defs.svh"

package sd_spi_pkg;

  // Encodings are the SD command indices
  typedef enum logic [5:0] {
    OP_GO_IDLE      = 6'd0,
    OP_SEND_IF_COND = 6'd8,
    OP_READ_SINGLE  = 6'd17
  } sd_opcode_e;

  typedef enum logic [1:0] {
    RESP_R1   = 2'd0,
    RESP_R7   = 2'd1,
    RESP_DATA = 2'd2
  } sd_resp_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT_START,
    RX_RECEIVING,
    RX_DONE
  } sd_rx_state_e;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_SEND,
    CTRL_GET_R1,
    CTRL_GET_DATA,
    CTRL_FINISH
  } sd_ctrl_state_e;

  typedef struct packed {
    sd_opcode_e  opcode;
    logic [31:0] arg;
  } sd_cmd_t;

  // Block data holds byte 0 in bits 7:0
  typedef struct packed {
    logic [7:0]                     r1;
    logic [31:0]                    r7;
    logic [`SD_BLOCK_BYTES*8-1:0]   data;
    logic                           crc_error;
    logic                           timeout;
  } sd_result_t;

endpackage

/* hdl/sd_spi_phy.sv */
// SCLK divider with chip select and MOSI launch and MISO sample strobes
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_spi_phy (
  input  logic clock,
  input  logic reset,
  input  logic active,
  output logic launch_tick,
  output logic sample_tick,
  output logic sclk,
  output logic cs_n
);

  localparam int DIV_W = $clog2(`SD_SCLK_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SD_SCLK_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             edge_now;

  // SCLK toggles at the end of each half period
  assign edge_now = active && (div_cnt == DIV_LAST);

  // Strobes lead the edge by one clock so users update on the edge itself
  assign launch_tick = edge_now && sclk;
  assign sample_tick = edge_now && !sclk;

  // Card is selected for the whole transaction
  assign cs_n = ~active;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end else if (!active) begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end else if (edge_now) begin
      div_cnt <= '0;
      sclk    <= ~sclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Bus parks low once the sequencer releases the link
  a_sclk_idle_low: assert property (
    @(posedge clock) disable iff (reset)
    !active |=> !sclk
  );

endmodule

/* hdl/sd_cmd_sender.sv */
// Command frame builder with serial CRC7, shifted out on MOSI
`timescale 1ns/1ps

module sd_cmd_sender (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  send_start,
  input  sd_spi_pkg::sd_cmd_t   cmd,
  input  logic                  launch_tick,
  output logic                  mosi,
  output logic                  send_done
);

  logic [39:0] frame;
  logic [39:0] sr;
  logic [6:0]  crc7;
  logic [6:0]  crc_next;
  logic [5:0]  bit_cnt;
  logic        sending;

  // Start bit 0, transmission bit 1, index and argument
  assign frame = {2'b01, cmd.opcode, cmd.arg};

  // CRC7 polynomial x^7 + x^3 + 1 over the bit now on the line
  assign crc_next = {crc7[5:0], 1'b0} ^ ({7{crc7[6] ^ mosi}} & 7'h09);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sending   <= 1'b0;
      bit_cnt   <= '0;
      send_done <= 1'b0;
      mosi      <= 1'b1;
    end else begin
      send_done <= 1'b0;
      if (send_start) begin
        sending <= 1'b1;
        bit_cnt <= '0;
        mosi    <= frame[39];
      end else if (sending && launch_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt < 6'd39) begin
          mosi <= sr[39];
        end else if (bit_cnt == 6'd39) begin
          mosi <= crc_next[6];
        end else if (bit_cnt < 6'd46) begin
          mosi <= crc7[6];
        end else begin
          // End bit, then the line idles high
          mosi <= 1'b1;
          if (bit_cnt == 6'd47) begin
            sending   <= 1'b0;
            send_done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (send_start) begin
      sr   <= {frame[38:0], 1'b1};
      crc7 <= '0;
    end else if (sending && launch_tick) begin
      sr <= {sr[38:0], 1'b1};
      if (bit_cnt < 6'd39) begin
        crc7 <= crc_next;
      end else if (bit_cnt == 6'd39) begin
        crc7 <= {crc_next[5:0], 1'b0};
      end else begin
        crc7 <= {crc7[5:0], 1'b0};
      end
    end
  end

endmodule

/* hdl/sd_receiver.sv */
// Response receiver with start-bit wait, bit counter, CRC16 check and timeout
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_receiver (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          rx_start,
  input  sd_spi_pkg::sd_resp_e          resp_kind,
  input  logic                          sample_tick,
  input  logic                          miso,
  output logic [`SD_BLOCK_BYTES*8-1:0]  rx_bits,
  output logic                          crc_error,
  output logic                          timeout,
  output logic                          rx_done
);

  localparam int DATA_W = `SD_BLOCK_BYTES * 8;
  localparam int CNT_W  = $clog2(DATA_W + 17);
  localparam int TO_W   = $clog2(`SD_RESP_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] CRC_BITS = CNT_W'(16);
  localparam logic [TO_W-1:0]  WAIT_LAST = TO_W'(`SD_RESP_TIMEOUT - 1);

  sd_spi_pkg::sd_rx_state_e state;
  sd_spi_pkg::sd_resp_e     kind_q;
  logic [CNT_W-1:0]         bit_cnt;
  logic [CNT_W-1:0]         load_val;
  logic [TO_W-1:0]          wait_cnt;
  logic [15:0]              crc16;
  logic [15:0]              crc_next;
  logic                     is_data;

  assign is_data = (kind_q == sd_spi_pkg::RESP_DATA);
  assign rx_done = (state == sd_spi_pkg::RX_DONE);

  // Bits left after the start bit, or after the token for a block
  always_comb begin
    case (kind_q)
      sd_spi_pkg::RESP_R1: load_val = CNT_W'(7);
      sd_spi_pkg::RESP_R7: load_val = CNT_W'(39);
      default:             load_val = CNT_W'(DATA_W + 16);
    endcase
  end

  // CRC16 x^16 + x^12 + x^5 + 1
  assign crc_next = {crc16[14:0], 1'b0} ^ ({16{crc16[15] ^ miso}} & 16'h1021);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= sd_spi_pkg::RX_IDLE;
      kind_q    <= sd_spi_pkg::RESP_R1;
      bit_cnt   <= '0;
      wait_cnt  <= '0;
      crc_error <= 1'b0;
      timeout   <= 1'b0;
    end else begin
      case (state)
        sd_spi_pkg::RX_IDLE: begin
          if (rx_start) begin
            kind_q    <= resp_kind;
            wait_cnt  <= '0;
            crc_error <= 1'b0;
            timeout   <= 1'b0;
            state     <= sd_spi_pkg::RX_WAIT_START;
          end
        end
        sd_spi_pkg::RX_WAIT_START: begin
          // First low bit is the R1 MSB or the last bit of token 0xFE
          if (sample_tick) begin
            if (!miso) begin
              bit_cnt <= load_val;
              state   <= sd_spi_pkg::RX_RECEIVING;
            end else if (wait_cnt == WAIT_LAST) begin
              timeout <= 1'b1;
              state   <= sd_spi_pkg::RX_DONE;
            end else begin
              wait_cnt <= wait_cnt + 1'b1;
            end
          end
        end
        sd_spi_pkg::RX_RECEIVING: begin
          if (sample_tick) begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == CNT_W'(1)) begin
              crc_error <= is_data && (crc_next != 16'h0000);
              state     <= sd_spi_pkg::RX_DONE;
            end
          end
        end
        default: state <= sd_spi_pkg::RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == sd_spi_pkg::RX_IDLE && rx_start) begin
      crc16 <= '0;
    end
    // R1 start bit is part of the response
    if (state == sd_spi_pkg::RX_WAIT_START && sample_tick && !miso && !is_data) begin
      rx_bits <= {rx_bits[DATA_W-2:0], miso};
    end
    if (state == sd_spi_pkg::RX_RECEIVING && sample_tick) begin
      if (is_data) begin
        crc16 <= crc_next;
      end
      // Shift register stops before the trailing CRC16
      if (!is_data || bit_cnt > CRC_BITS) begin
        rx_bits <= {rx_bits[DATA_W-2:0], miso};
      end
    end
  end

  a_start_in_idle: assert property (
    @(posedge clock) disable iff (reset)
    rx_start |-> state == sd_spi_pkg::RX_IDLE
  );

endmodule

/* hdl/sd_transaction_ctrl.sv */
// Transaction sequencer for send, R1 or R7 receive and block receive
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_transaction_ctrl (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          start,
  input  sd_spi_pkg::sd_cmd_t           cmd,
  output logic                          busy,
  output logic                          finished,
  output sd_spi_pkg::sd_result_t        result,
  output logic                          active,
  output logic                          send_start,
  output logic                          rx_start,
  output sd_spi_pkg::sd_resp_e          resp_kind,
  input  logic                          send_done,
  input  logic                          rx_done,
  input  logic [`SD_BLOCK_BYTES*8-1:0]  rx_bits,
  input  logic                          crc_error,
  input  logic                          timeout
);

  localparam int BYTES = `SD_BLOCK_BYTES;

  sd_spi_pkg::sd_ctrl_state_e state;
  sd_spi_pkg::sd_cmd_t        cmd_q;
  logic [7:0]                 r1_now;
  logic [BYTES*8-1:0]         block_now;

  assign busy = (state != sd_spi_pkg::CTRL_IDLE);

  // R7 carries R1 above its 32-bit payload
  assign r1_now = (resp_kind == sd_spi_pkg::RESP_R7) ? rx_bits[39:32] : rx_bits[7:0];

  // First byte received lands highest in the shift register
  always_comb begin
    for (int i = 0; i < BYTES; i++) begin
      block_now[8*i +: 8] = rx_bits[8*(BYTES-1-i) +: 8];
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= sd_spi_pkg::CTRL_IDLE;
      active     <= 1'b0;
      send_start <= 1'b0;
      rx_start   <= 1'b0;
      finished   <= 1'b0;
      resp_kind  <= sd_spi_pkg::RESP_R1;
    end else begin
      send_start <= 1'b0;
      rx_start   <= 1'b0;
      finished   <= 1'b0;
      case (state)
        sd_spi_pkg::CTRL_IDLE: begin
          if (start) begin
            active     <= 1'b1;
            send_start <= 1'b1;
            state      <= sd_spi_pkg::CTRL_SEND;
          end
        end
        sd_spi_pkg::CTRL_SEND: begin
          if (send_done) begin
            rx_start  <= 1'b1;
            resp_kind <= (cmd_q.opcode == sd_spi_pkg::OP_SEND_IF_COND) ?
                         sd_spi_pkg::RESP_R7 : sd_spi_pkg::RESP_R1;
            state     <= sd_spi_pkg::CTRL_GET_R1;
          end
        end
        sd_spi_pkg::CTRL_GET_R1: begin
          if (rx_done) begin
            // Block follows only when the card accepted the read
            if (!timeout && cmd_q.opcode == sd_spi_pkg::OP_READ_SINGLE && r1_now == 8'h00) begin
              rx_start  <= 1'b1;
              resp_kind <= sd_spi_pkg::RESP_DATA;
              state     <= sd_spi_pkg::CTRL_GET_DATA;
            end else begin
              state <= sd_spi_pkg::CTRL_FINISH;
            end
          end
        end
        sd_spi_pkg::CTRL_GET_DATA: begin
          if (rx_done) begin
            state <= sd_spi_pkg::CTRL_FINISH;
          end
        end
        default: begin
          active   <= 1'b0;
          finished <= 1'b1;
          state    <= sd_spi_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == sd_spi_pkg::CTRL_IDLE && start) begin
      cmd_q  <= cmd;
      result <= '0;
    end
    if (state == sd_spi_pkg::CTRL_GET_R1 && rx_done) begin
      result.r1      <= r1_now;
      result.timeout <= timeout;
      if (resp_kind == sd_spi_pkg::RESP_R7) begin
        result.r7 <= rx_bits[31:0];
      end
    end
    if (state == sd_spi_pkg::CTRL_GET_DATA && rx_done) begin
      result.data      <= block_now;
      result.crc_error <= crc_error;
      result.timeout   <= timeout;
    end
  end

endmodule

/* hdl/sd_apb_regs.sv */
// APB register slave for command, argument, status, response and block data
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_apb_regs (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`SD_APB_ADDR_W-1:0]     paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          start,
  output sd_spi_pkg::sd_cmd_t           cmd,
  input  logic                          busy,
  input  logic                          finished,
  input  sd_spi_pkg::sd_result_t        result
);

  localparam int AW = `SD_APB_ADDR_W;
  localparam int DATA_WORDS = `SD_BLOCK_BYTES / 4;
  localparam logic [AW-1:0] ADDR_CMD    = AW'('h00);
  localparam logic [AW-1:0] ADDR_ARG    = AW'('h04);
  localparam logic [AW-1:0] ADDR_STATUS = AW'('h08);
  localparam logic [AW-1:0] ADDR_RESP   = AW'('h0C);
  localparam logic [AW-1:0] ADDR_DATA   = AW'('h10);
  localparam logic [AW-1:0] ADDR_END    = AW'('h10 + 4 * DATA_WORDS);

  sd_spi_pkg::sd_result_t result_q;
  logic [31:0]            arg_q;
  logic [AW-1:0]          data_off;
  logic                   access;
  logic                   hit_data;
  logic                   mapped;
  logic                   cmd_write;
  logic                   busy_any;
  logic                   done;

  assign access   = psel && penable;
  assign data_off = paddr - ADDR_DATA;
  assign hit_data = (paddr >= ADDR_DATA) && (paddr < ADDR_END);
  assign mapped   = (paddr[1:0] == 2'b00) && ((paddr <= ADDR_RESP) || hit_data);

  // Start pulse covers the cycle before the sequencer reports busy
  assign busy_any  = busy || start;
  assign cmd_write = access && pwrite && (paddr == ADDR_CMD);

  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || (cmd_write && busy_any));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      start    <= 1'b0;
      done     <= 1'b0;
      arg_q    <= '0;
      result_q <= '0;
    end else begin
      start <= 1'b0;
      if (cmd_write && !busy_any) begin
        start <= 1'b1;
        done  <= 1'b0;
      end
      if (finished) begin
        done     <= 1'b1;
        result_q <= result;
      end
      if (access && pwrite && paddr == ADDR_ARG) begin
        arg_q <= pwdata;
      end
    end
  end

  // Command is held stable for the whole transaction
  always_ff @(posedge clock) begin
    if (cmd_write && !busy_any) begin
      cmd.opcode <= sd_spi_pkg::sd_opcode_e'(pwdata[5:0]);
      cmd.arg    <= arg_q;
    end
  end

  always_comb begin
    prdata = '0;
    if (hit_data) begin
      prdata = result_q.data[32*data_off[AW-1:2] +: 32];
    end else begin
      case (paddr)
        ADDR_CMD:    prdata = {26'd0, cmd.opcode};
        ADDR_ARG:    prdata = arg_q;
        ADDR_STATUS: prdata = {16'd0, result_q.r1, 4'd0, result_q.timeout,
                               result_q.crc_error, done, busy_any};
        ADDR_RESP:   prdata = result_q.r7;
        default:     prdata = '0;
      endcase
    end
  end

  // No wait states, so every access phase directly follows a setup phase
  a_apb_setup_first: assert property (
    @(posedge clock) disable iff (reset)
    psel && penable |-> $past(psel && !penable)
  );

endmodule

/* hdl/sd_spi_host.sv */
// SPI-mode SD host top level with APB slave, sequencer, sender, receiver and phy
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_spi_host (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`SD_APB_ADDR_W-1:0] paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      sclk,
  output logic                      cs_n,
  output logic                      mosi,
  input  logic                      miso
);

  sd_spi_pkg::sd_cmd_t          cmd;
  sd_spi_pkg::sd_result_t       result;
  sd_spi_pkg::sd_resp_e         resp_kind;
  logic [`SD_BLOCK_BYTES*8-1:0] rx_bits;
  logic start, busy, finished, active;
  logic send_start, send_done, rx_start, rx_done;
  logic crc_error, timeout, launch_tick, sample_tick;

  sd_apb_regs i_apb_regs (
    .clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .start, .cmd, .busy, .finished, .result
  );

  sd_transaction_ctrl i_transaction_ctrl (
    .clock, .reset, .start, .cmd, .busy, .finished, .result, .active,
    .send_start, .rx_start, .resp_kind, .send_done, .rx_done, .rx_bits,
    .crc_error, .timeout
  );

  sd_cmd_sender i_cmd_sender (
    .clock, .reset, .send_start, .cmd, .launch_tick, .mosi, .send_done
  );

  sd_receiver i_receiver (
    .clock, .reset, .rx_start, .resp_kind, .sample_tick, .miso, .rx_bits,
    .crc_error, .timeout, .rx_done
  );

  sd_spi_phy i_spi_phy (
    .clock, .reset, .active, .launch_tick, .sample_tick, .sclk, .cs_n
  );

endmodule

/* sim/sd_card_model.sv */
// Behavioral SPI-mode SD card for CMD0, CMD8 and CMD17 with CRC and silence faults
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module sd_card_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic frame_error
);

  logic [47:0] frame;
  logic        resp_bits[$];

  // CRC7 x^7 + x^3 + 1, one bit at a time
  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic b);
    logic fb;
    fb = crc[6] ^ b;
    return fb ? ({crc[5:0], 1'b0} ^ 7'h09) : {crc[5:0], 1'b0};
  endfunction

  // CRC16-CCITT x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic b);
    logic fb;
    fb = crc[15] ^ b;
    return fb ? ({crc[14:0], 1'b0} ^ 16'h1021) : {crc[14:0], 1'b0};
  endfunction

  task automatic push_byte(input logic [7:0] value);
    for (int i = 7; i >= 0; i--) begin
      resp_bits.push_back(value[i]);
    end
  endtask

  initial begin : card
    logic [6:0]  crc7;
    logic [15:0] crc16;
    logic [7:0]  value;
    logic [31:0] arg;
    miso        = 1'b1;
    frame_error = 1'b0;
    forever begin
      wait (!cs_n);
      for (int i = 0; i < 48; i++) begin
        @(posedge sclk);
        frame = {frame[46:0], mosi};
      end
      crc7 = '0;
      for (int i = 47; i >= 8; i--) begin
        crc7 = crc7_step(crc7, frame[i]);
      end
      if (frame[47:46] != 2'b01 || frame[7:1] != crc7 || !frame[0]) begin
        frame_error = 1'b1;
      end
      arg = frame[39:8];
      resp_bits.delete();
      // Bit 30 keeps the card silent
      if (!arg[30]) begin
        case (frame[45:40])
          6'd0: push_byte(8'h01);
          6'd8: begin
            push_byte(8'h00);
            for (int k = 3; k >= 0; k--) begin
              push_byte(arg[8*k +: 8]);
            end
          end
          6'd17: begin
            // R1, one idle byte, start token, block, CRC16
            push_byte(8'h00);
            push_byte(8'hFF);
            push_byte(8'hFE);
            crc16 = '0;
            for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
              value = arg[7:0] + 8'(i);
              push_byte(value);
              for (int b = 7; b >= 0; b--) begin
                crc16 = crc16_step(crc16, value[b]);
              end
            end
            if (arg[31]) begin
              crc16 = ~crc16;
            end
            push_byte(crc16[15:8]);
            push_byte(crc16[7:0]);
          end
          default: push_byte(8'h00);
        endcase
      end
      // Eight idle bits, then the answer on falling edges
      repeat (8) begin
        @(negedge sclk);
        miso = 1'b1;
      end
      while (resp_bits.size() > 0) begin
        @(negedge sclk);
        miso = resp_bits.pop_front();
      end
      wait (cs_n);
      miso = 1'b1;
    end
  end

endmodule

/* sim/tb_sd_spi_host.sv */
// Clock, reset, APB tasks, card model, checking assertions and watchdog for the SD SPI host
`timescale 1ns/1ps
`include "sd_spi_defs.svh"

module tb_sd_spi_host;

  localparam int CLK_PERIOD = 20;
  // 4 x 2000 SCLK periods
  localparam int WATCHDOG = 4 * 2000 * 2 * `SD_SCLK_DIV * CLK_PERIOD;

  logic                      clock;
  logic                      reset;
  logic                      psel, penable, pwrite;
  logic [`SD_APB_ADDR_W-1:0] paddr;
  logic [31:0]               pwdata, prdata;
  logic                      pready, pslverr;
  logic                      sclk, cs_n, mosi, miso, frame_error;

  // Expected values seen by the checking assertions
  logic        check_read;
  logic        exp_slverr;
  logic        txn_open;
  logic [31:0] exp_rdata;
  logic [31:0] exp_mask;
  string       reg_name;

  sd_spi_host i_sd_spi_host (
    .clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .sclk, .cs_n, .mosi, .miso
  );

  sd_card_model i_card_model (.sclk, .cs_n, .mosi, .miso, .frame_error);

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic fail_and_stop();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error at %0d ns: %s expected 0x%08h, actual 0x%08h", $time, name, exp, act);
    fail_and_stop();
  endtask

  a_read_value: assert property (
    @(posedge clock) disable iff (reset)
    psel && penable && !pwrite && check_read |-> (prdata & exp_mask) == (exp_rdata & exp_mask)
  ) else report_mismatch(reg_name, exp_rdata & exp_mask, $sampled(prdata) & exp_mask);

  a_slave_error: assert property (
    @(posedge clock) disable iff (reset)
    psel && penable |-> pslverr == exp_slverr
  ) else report_mismatch("pslverr", 32'(exp_slverr), 32'($sampled(pslverr)));

  a_no_wait_states: assert property (@(posedge clock) disable iff (reset) psel |-> pready)
    else begin
      $display("APB pready was low during a transfer");
      fail_and_stop();
    end

  a_cs_in_txn: assert property (@(posedge clock) disable iff (reset) !cs_n |-> txn_open)
    else begin
      $display("Chip select went low outside a transaction");
      fail_and_stop();
    end

  // Idle SPI lines between transactions
  a_lines_idle: assert property (
    @(posedge clock) disable iff (reset)
    cs_n && $past(cs_n) |-> !sclk && mosi
  ) else begin
    $display("SCLK or MOSI not idle while chip select was high");
    fail_and_stop();
  end

  a_frame_ok: assert property (@(posedge clock) disable iff (reset) !frame_error)
    else begin
      $display("Card received a command frame with a bad start bits, CRC7 or end bit");
      fail_and_stop();
    end

  task automatic apb_write(input logic [`SD_APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic err);
    psel       = 1'b1;
    pwrite     = 1'b1;
    paddr      = addr;
    pwdata     = data;
    exp_slverr = err;
    @(posedge clock);
    #2 penable = 1'b1;
    @(posedge clock);
    #2 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`SD_APB_ADDR_W-1:0] addr, input logic err,
                          output logic [31:0] data);
    psel       = 1'b1;
    pwrite     = 1'b0;
    paddr      = addr;
    exp_slverr = err;
    @(posedge clock);
    #2 penable = 1'b1;
    // Settled half a cycle before the completing edge
    @(negedge clock);
    data = prdata;
    @(posedge clock);
    #2 psel = 1'b0;
    penable    = 1'b0;
    check_read = 1'b0;
  endtask

  task automatic read_check(input logic [`SD_APB_ADDR_W-1:0] addr, input string name,
                            input logic [31:0] exp, input logic [31:0] mask);
    logic [31:0] rdata;
    reg_name   = name;
    exp_rdata  = exp;
    exp_mask   = mask;
    check_read = 1'b1;
    apb_read(addr, 1'b0, rdata);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      apb_read(8'h08, 1'b0, status);
    end
    txn_open = 1'b0;
  endtask

  task automatic run_command(input logic [5:0] opcode, input logic [31:0] arg);
    apb_write(8'h04, arg, 1'b0);
    txn_open = 1'b1;
    apb_write(8'h00, {26'd0, opcode}, 1'b0);
    // New start sets busy and clears done
    read_check(8'h08, "STATUS", 32'h1, 32'h3);
    wait_done();
  endtask

  // Byte i of a block is the argument's low byte plus i
  function automatic logic [31:0] block_word(input logic [31:0] arg, input int word);
    logic [31:0] value;
    for (int i = 0; i < 4; i++) begin
      value[8*i +: 8] = arg[7:0] + 8'(4 * word + i);
    end
    return value;
  endfunction

  task automatic check_block(input logic [31:0] arg);
    for (int w = 0; w < `SD_BLOCK_BYTES / 4; w++) begin
      read_check(8'(8'h10 + 4 * w), $sformatf("DATA[%0d]", w), block_word(arg, w),
                 32'hFFFF_FFFF);
    end
  endtask

  // Silent card, r1 left unchecked
  task automatic check_silent(input logic [5:0] opcode);
    run_command(opcode, 32'h4000_0000 | {24'd0, 8'($urandom)});
    read_check(8'h08, "STATUS", 32'h0000_000A, 32'h0000_00FF);
  endtask

  initial begin : watchdog
    #(WATCHDOG);
    $display("Watchdog expired before the tests completed");
    fail_and_stop();
  end

  initial begin : stimulus
    logic [31:0] arg;
    logic [31:0] rdata;
    clock      = 1'b0;
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    check_read = 1'b0;
    exp_slverr = 1'b0;
    txn_open   = 1'b0;
    exp_rdata  = '0;
    exp_mask   = '0;
    reg_name   = "";
    void'($urandom(32'h6d75));
    repeat (8) @(posedge clock);
    #2 reset = 1'b0;

    run_command(sd_spi_pkg::OP_GO_IDLE, 32'h0);
    read_check(8'h08, "STATUS", 32'h0000_0102, 32'hFFFF_FFFF);

    for (int n = 0; n < 2; n++) begin
      arg = {24'h000001, 8'($urandom)};
      run_command(sd_spi_pkg::OP_SEND_IF_COND, arg);
      read_check(8'h08, "STATUS", 32'h0000_0002, 32'hFFFF_FFFF);
      read_check(8'h0C, "RESP", arg, 32'hFFFF_FFFF);
    end

    arg = {24'h000200, 8'($urandom)};
    run_command(sd_spi_pkg::OP_READ_SINGLE, arg);
    read_check(8'h08, "STATUS", 32'h0000_0002, 32'hFFFF_FFFF);
    check_block(arg);

    // Inverted CRC16 from the card
    run_command(sd_spi_pkg::OP_READ_SINGLE, {24'h800000, 8'($urandom)});
    read_check(8'h08, "STATUS", 32'h0000_0006, 32'hFFFF_FFFF);

    check_silent(sd_spi_pkg::OP_GO_IDLE);
    check_silent(sd_spi_pkg::OP_SEND_IF_COND);
    check_silent(sd_spi_pkg::OP_READ_SINGLE);

    // Second CMD write lands while the first transaction runs
    arg = {24'h000001, 8'($urandom)};
    apb_write(8'h04, arg, 1'b0);
    txn_open = 1'b1;
    apb_write(8'h00, {26'd0, sd_spi_pkg::OP_SEND_IF_COND}, 1'b0);
    apb_write(8'h04, ~arg & 32'h00FF_FFFF, 1'b0);
    apb_write(8'h00, {26'd0, sd_spi_pkg::OP_READ_SINGLE}, 1'b1);
    wait_done();
    read_check(8'h08, "STATUS", 32'h0000_0002, 32'hFFFF_FFFF);
    read_check(8'h0C, "RESP", arg, 32'hFFFF_FFFF);
    read_check(8'h00, "CMD", 32'd8, 32'h0000_003F);

    // Unmapped address
    apb_read(8'h40, 1'b1, rdata);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* sd_spi_host.f */
+incdir+hdl
hdl/sd_spi_pkg.sv
hdl/sd_spi_phy.sv
hdl/sd_cmd_sender.sv
hdl/sd_receiver.sv
hdl/sd_transaction_ctrl.sv
hdl/sd_apb_regs.sv
hdl/sd_spi_host.sv
sim/sd_card_model.sv
sim/tb_sd_spi_host.sv
